// ==== include/mem_test_defs.svh ====
`ifndef MEM_TEST_DEFS_SVH
`define MEM_TEST_DEFS_SVH

// avalon user port of the DDR3 controller, word addressed
`define MEM_ADDR_W 24
`define MEM_DATA_W 64
`define MEM_BE_W 8
`define MEM_SIZE_W 7

// base word of the walking test, each address stores this XOR its index
`define MEM_PATTERN 64'hdeadfadebabebeef

// by default the whole 24 bit word space is walked
`define MEM_TEST_BITS_DEFAULT 24

// a 24 bit divider gives a visible blink rate at typical fabric clocks
`define LED_DIV_BITS_DEFAULT 24

`endif

// ==== logic/mem_test_pkg.sv ====
package mem_test_pkg;

    // top level test sequence, one write and one read per address
    typedef enum logic [2:0] {
        wait_cal,
        write,
        read,
        next,      // read issued, index advances once it is accepted
        done,
        error
    } seq_state_t;

    // what the three LEDs show
    typedef enum logic [1:0] {
        off,
        blink,     // all LEDs toggle together
        count      // binary count on the LEDs
    } led_mode_t;

endpackage

// ==== logic/cal_status_sync.sv ====
`timescale 1ns/1ps

module cal_status_sync (
    input  logic clk,
    input  logic reset_n,
    input  logic ddr3_init_done,
    input  logic ddr3_cal_success,
    input  logic ddr3_cal_fail,
    output logic cal_ok,
    output logic cal_bad
);

    logic [2:0] status_meta;
    logic [2:0] status_sync;  // init done, success, fail
    logic ok_q;
    logic bad_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            status_meta <= 3'b000;
            status_sync <= 3'b000;
            ok_q <= 1'b0;
            bad_q <= 1'b0;
        end else begin
            status_meta <= {ddr3_init_done, ddr3_cal_success, ddr3_cal_fail};
            status_sync <= status_meta;
            ok_q <= cal_ok;
            bad_q <= cal_bad;
        end
    end

    // the verdict is taken straight from the second stage, then held
    assign cal_ok = ok_q | (status_sync[2] & status_sync[1] & ~bad_q);
    assign cal_bad = bad_q | (status_sync[2] & status_sync[0] & ~status_sync[1] & ~ok_q);

endmodule

// ==== logic/mem_test_sequencer.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module mem_test_sequencer #(
    parameter int test_bits = `MEM_TEST_BITS_DEFAULT
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cal_ok,
    input  logic                    cal_bad,
    input  logic                    avl_ready,
    input  logic                    chk_fail,
    input  logic                    chk_done,
    output logic                    avl_burstbegin,
    output logic [`MEM_ADDR_W-1:0]  avl_addr,
    output logic [`MEM_DATA_W-1:0]  avl_wdata,
    output logic [`MEM_BE_W-1:0]    avl_be,
    output logic                    avl_read_req,
    output logic                    avl_write_req,
    output logic [`MEM_SIZE_W-1:0]  avl_size,
    output mem_test_pkg::led_mode_t led_mode
);

    import mem_test_pkg::*;

    localparam int addr_w = `MEM_ADDR_W;
    localparam int data_w = `MEM_DATA_W;
    localparam int size_w = `MEM_SIZE_W;

    seq_state_t state;
    seq_state_t state_next;

    // the top bit marks that every address has been read back
    logic [test_bits:0] index;
    logic [test_bits:0] index_next;
    logic [test_bits:0] index_inc;
    logic req_idle;

    logic avl_burstbegin_next;
    logic [addr_w-1:0] avl_addr_next;
    logic [data_w-1:0] avl_wdata_next;
    logic [`MEM_BE_W-1:0] avl_be_next;
    logic avl_read_req_next;
    logic avl_write_req_next;
    logic [size_w-1:0] avl_size_next;
    led_mode_t led_mode_next;

    assign index_inc = index + 1'b1;
    assign req_idle = !(avl_write_req || avl_read_req);

    always_comb begin
        state_next = state;
        index_next = index;
        led_mode_next = led_mode;
        avl_burstbegin_next = avl_burstbegin;
        avl_addr_next = avl_addr;
        avl_wdata_next = avl_wdata;
        avl_be_next = avl_be;
        avl_read_req_next = avl_read_req;
        avl_write_req_next = avl_write_req;
        avl_size_next = avl_size;

        case (state)
            wait_cal: begin
                if (cal_ok) begin
                    state_next = write;
                end else if (cal_bad) begin
                    state_next = error;
                end
            end

            write: begin
                avl_burstbegin_next = 1'b1;
                avl_addr_next = addr_w'(index[test_bits-1:0]);
                avl_wdata_next = `MEM_PATTERN ^ data_w'(index[test_bits-1:0]);
                avl_be_next = '1;
                avl_size_next = size_w'(1);
                avl_write_req_next = 1'b1;
                state_next = read;
            end

            read: begin
                avl_burstbegin_next = 1'b0;
                if (avl_ready) begin  // write taken, read back the same address
                    avl_write_req_next = 1'b0;
                    avl_burstbegin_next = 1'b1;
                    avl_read_req_next = 1'b1;
                    state_next = next;
                end
            end

            next: begin
                avl_burstbegin_next = 1'b0;
                if (avl_read_req) begin
                    if (avl_ready) begin
                        avl_read_req_next = 1'b0;
                        index_next = index_inc;
                        if (!index_inc[test_bits]) begin
                            state_next = write;
                        end
                    end
                end else if (index[test_bits] && chk_done) begin
                    // last read is out, the checker has to see every beat first
                    state_next = done;
                    led_mode_next = count;
                end
            end

            done, error: begin
            end

            default: begin
                state_next = error;
            end
        endcase

        // a request already on the bus has to be taken before it is dropped
        if (chk_fail || state_next == error) begin
            state_next = error;
            led_mode_next = blink;
            avl_burstbegin_next = 1'b0;
            if (req_idle || avl_ready) begin
                avl_write_req_next = 1'b0;
                avl_read_req_next = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= wait_cal;
            index <= '0;
            led_mode <= off;
            avl_burstbegin <= 1'b0;
            avl_addr <= '0;
            avl_wdata <= '0;
            avl_be <= '0;
            avl_read_req <= 1'b0;
            avl_write_req <= 1'b0;
            avl_size <= '0;
        end else begin
            state <= state_next;
            index <= index_next;
            led_mode <= led_mode_next;
            avl_burstbegin <= avl_burstbegin_next;
            avl_addr <= avl_addr_next;
            avl_wdata <= avl_wdata_next;
            avl_be <= avl_be_next;
            avl_read_req <= avl_read_req_next;
            avl_write_req <= avl_write_req_next;
            avl_size <= avl_size_next;
        end
    end

endmodule

// ==== logic/mem_read_checker.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module mem_read_checker #(
    parameter int test_bits = `MEM_TEST_BITS_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   avl_rdata_valid,
    input  logic [`MEM_DATA_W-1:0] avl_rdata,
    output logic                   chk_fail,
    output logic                   chk_done
);

    localparam int data_w = `MEM_DATA_W;

    // reads come back in request order, so a plain counter tracks the address
    logic [test_bits-1:0] exp_index;
    logic [data_w-1:0] exp_data;
    logic beat_ok;
    logic last_beat;

    assign exp_data = `MEM_PATTERN ^ data_w'(exp_index);
    assign beat_ok = (avl_rdata == exp_data);
    assign last_beat = &exp_index;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exp_index <= '0;
            chk_fail <= 1'b0;
            chk_done <= 1'b0;
        end else if (avl_rdata_valid) begin
            exp_index <= exp_index + 1'b1;
            if (!chk_done) begin
                if (!beat_ok) begin
                    chk_fail <= 1'b1;
                end else if (last_beat && !chk_fail) begin
                    chk_done <= 1'b1;  // every address matched
                end
            end
        end
    end

endmodule

// ==== logic/status_led_driver.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module status_led_driver #(
    parameter int div_bits = `LED_DIV_BITS_DEFAULT
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  mem_test_pkg::led_mode_t led_mode,
    output logic [2:0]              leds_n
);

    import mem_test_pkg::*;

    logic [div_bits-1:0] div_cnt;
    logic tick;
    logic [2:0] leds;

    // one tick per full turn of the divider
    assign tick = &div_cnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            leds <= 3'b000;
        end else begin
            case (led_mode)
                blink: begin
                    if (tick) begin
                        leds <= ~leds;
                    end
                end
                count: begin
                    if (tick) begin
                        leds <= leds + 3'd1;
                    end
                end
                default: begin
                    leds <= 3'b000;
                end
            endcase
        end
    end

    assign leds_n = ~leds;  // the board LEDs light on a low level

endmodule

// ==== logic/mem_test_top.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module mem_test_top #(
    parameter int test_bits = `MEM_TEST_BITS_DEFAULT,
    parameter int led_div_bits = `LED_DIV_BITS_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset_n,
    output logic                   avl_burstbegin,
    output logic [`MEM_ADDR_W-1:0] avl_addr,
    output logic [`MEM_DATA_W-1:0] avl_wdata,
    output logic [`MEM_BE_W-1:0]   avl_be,
    output logic                   avl_read_req,
    output logic                   avl_write_req,
    output logic [`MEM_SIZE_W-1:0] avl_size,
    input  logic                   avl_ready,
    input  logic                   avl_rdata_valid,
    input  logic [`MEM_DATA_W-1:0] avl_rdata,
    input  logic                   ddr3_init_done,
    input  logic                   ddr3_cal_success,
    input  logic                   ddr3_cal_fail,
    output logic [2:0]             leds_n
);

    import mem_test_pkg::*;

    logic cal_ok;
    logic cal_bad;
    logic chk_fail;
    logic chk_done;
    led_mode_t led_mode;

    cal_status_sync cal_status_sync_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .ddr3_init_done   (ddr3_init_done),
        .ddr3_cal_success (ddr3_cal_success),
        .ddr3_cal_fail    (ddr3_cal_fail),
        .cal_ok           (cal_ok),
        .cal_bad          (cal_bad)
    );

    mem_test_sequencer #(
        .test_bits (test_bits)
    ) mem_test_sequencer_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .cal_ok         (cal_ok),
        .cal_bad        (cal_bad),
        .avl_ready      (avl_ready),
        .chk_fail       (chk_fail),
        .chk_done       (chk_done),
        .avl_burstbegin (avl_burstbegin),
        .avl_addr       (avl_addr),
        .avl_wdata      (avl_wdata),
        .avl_be         (avl_be),
        .avl_read_req   (avl_read_req),
        .avl_write_req  (avl_write_req),
        .avl_size       (avl_size),
        .led_mode       (led_mode)
    );

    // read data needs no request context, it is checked in arrival order
    mem_read_checker #(
        .test_bits (test_bits)
    ) mem_read_checker_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .avl_rdata_valid (avl_rdata_valid),
        .avl_rdata       (avl_rdata),
        .chk_fail        (chk_fail),
        .chk_done        (chk_done)
    );

    status_led_driver #(
        .div_bits (led_div_bits)
    ) status_led_driver_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .led_mode (led_mode),
        .leds_n   (leds_n)
    );

endmodule

// ==== verif/mem_test_checker.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module mem_test_checker (
    input logic                        clk,
    input logic                        reset_n,
    input logic                        avl_ready,
    input logic                        avl_burstbegin,
    input logic [`MEM_ADDR_W-1:0]      avl_addr,
    input logic [`MEM_DATA_W-1:0]      avl_wdata,
    input logic [`MEM_BE_W-1:0]        avl_be,
    input logic                        avl_read_req,
    input logic                        avl_write_req,
    input logic [`MEM_SIZE_W-1:0]      avl_size,
    input mem_test_pkg::seq_state_t    state
);

    import mem_test_pkg::*;

    logic req;
    int fail_count = 0;

    assign req = avl_write_req || avl_read_req;

    // while the controller stalls, the request and its fields stay put
    stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (req && !avl_ready) |=>
            $stable({avl_write_req, avl_read_req, avl_addr, avl_wdata, avl_be, avl_size}))
        else begin
            fail_count++;
            $error("request changed while avl_ready was low");
        end

    one_kind: assert property (@(posedge clk) disable iff (!reset_n)
        !(avl_write_req && avl_read_req))
        else begin
            fail_count++;
            $error("read and write requested in the same cycle");
        end

    burst_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
        avl_burstbegin |-> req)
        else begin
            fail_count++;
            $error("burstbegin high without a request");
        end

    burst_first_only: assert property (@(posedge clk) disable iff (!reset_n)
        (req && !avl_ready) |=> !avl_burstbegin)
        else begin
            fail_count++;
            $error("burstbegin repeated on a stalled request");
        end

    idle_before_cal: assert property (@(posedge clk) disable iff (!reset_n)
        (state == wait_cal) |-> !req)
        else begin
            fail_count++;
            $error("request issued before calibration finished");
        end

endmodule

// ==== verif/mem_test_tb.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module mem_test_tb;

    localparam int num_words = 16;
    localparam int run_clean = 0;
    localparam int run_corrupt = 1;
    localparam int run_cal_fail = 2;
    localparam int req_w = `MEM_ADDR_W + `MEM_DATA_W + `MEM_BE_W + `MEM_SIZE_W + 2;

    logic clk;
    logic reset_n;
    logic avl_burstbegin;
    logic [`MEM_ADDR_W-1:0] avl_addr;
    logic [`MEM_DATA_W-1:0] avl_wdata;
    logic [`MEM_BE_W-1:0] avl_be;
    logic avl_read_req;
    logic avl_write_req;
    logic [`MEM_SIZE_W-1:0] avl_size;
    logic avl_ready;
    logic avl_rdata_valid;
    logic [`MEM_DATA_W-1:0] avl_rdata;
    logic ddr3_init_done;
    logic ddr3_cal_success;
    logic ddr3_cal_fail;
    logic [2:0] leds_n;

    logic [15:0] lfsr = 16'd52;
    int run_mode;
    int write_count;
    int beat_count;
    int cycle;
    int corrupt_beat;
    int corrupt_bit;
    logic corrupt_applied;
    logic write_open;  // a write was taken and its read is still due
    logic [`MEM_ADDR_W-1:0] write_addr;
    logic stalled;
    logic [req_w-1:0] stalled_req;
    logic [`MEM_DATA_W-1:0] mem [num_words];
    logic [`MEM_DATA_W-1:0] rd_data_q[$];
    int rd_due_q[$];
    logic checker_quiet;

    mem_test_top #(.test_bits(4), .led_div_bits(3)) mem_test_top_inst (.*);

    bind mem_test_sequencer mem_test_checker mem_test_checker_inst (.*);

    // the bound protocol checker counts its failed assertions
    assign checker_quiet =
        (mem_test_top_inst.mem_test_sequencer_inst.mem_test_checker_inst.fail_count == 0);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // word stored at the n-th accepted write
    function automatic logic [`MEM_DATA_W-1:0] expected_word(input int count);
        logic [`MEM_DATA_W-1:0] index;
        index = count;
        return `MEM_PATTERN ^ index;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    always @(negedge clk) begin
        assert (checker_quiet) else fail_now("a protocol assertion failed in the bound checker");
    end

    always @(posedge clk) begin : memory_model
        logic [`MEM_DATA_W-1:0] beat;
        logic [req_w-1:0] req_now;
        logic first_cycle;
        int value;
        req_now = {avl_write_req, avl_read_req, avl_addr, avl_wdata, avl_be, avl_size};
        if (!reset_n) begin
            write_count = 0;
            beat_count = 0;
            cycle = 0;
            write_open = 1'b0;
            stalled = 1'b0;
            corrupt_applied = 1'b0;
            rd_data_q.delete();
            rd_due_q.delete();
            avl_ready <= 1'b0;
            avl_rdata_valid <= 1'b0;
        end else begin
            cycle++;
            if (stalled) begin
                assert (req_now == stalled_req)
                else fail_now($sformatf("error: stalled request = 0x%0h, expected 0x%0h",
                                        req_now, stalled_req));
            end
            // a request is new unless it was left waiting at the last edge
            first_cycle = (avl_write_req || avl_read_req) && !stalled;
            assert (avl_burstbegin == first_cycle)
            else fail_now($sformatf("error: avl_burstbegin = 0x%0h, expected 0x%0h",
                                    avl_burstbegin, first_cycle));
            assert (!(avl_write_req && avl_read_req))
            else fail_now("read and write requests were driven together");
            if (run_mode == run_cal_fail) begin
                assert (!avl_write_req && !avl_read_req)
                else fail_now("a request was issued although calibration failed");
            end
            if (avl_write_req && avl_ready) begin
                assert (avl_addr == write_count)
                else fail_now($sformatf("error: avl_addr = 0x%0h, expected 0x%0h",
                                        avl_addr, write_count));
                assert (avl_wdata == expected_word(write_count))
                else fail_now($sformatf("error: avl_wdata = 0x%0h, expected 0x%0h",
                                        avl_wdata, expected_word(write_count)));
                assert (avl_be == '1)
                else fail_now($sformatf("error: avl_be = 0x%0h, expected 0xff", avl_be));
                assert (avl_size == 1)
                else fail_now($sformatf("error: avl_size = 0x%0h, expected 0x1", avl_size));
                mem[avl_addr[3:0]] = avl_wdata;
                write_addr = avl_addr;
                write_open = 1'b1;
                write_count++;
            end
            if (avl_read_req && avl_ready) begin
                assert (write_open) else fail_now("a read was issued without a write before it");
                assert (avl_addr == write_addr)
                else fail_now($sformatf("error: avl_addr = 0x%0h, expected 0x%0h",
                                        avl_addr, write_addr));
                draw_bits(2, value);
                rd_data_q.push_back(mem[avl_addr[3:0]]);
                rd_due_q.push_back(cycle + value + 1);  // latency of 1 to 4 cycles
                write_open = 1'b0;
            end
            stalled = (avl_write_req || avl_read_req) && !avl_ready;
            stalled_req = req_now;
            avl_rdata_valid <= 1'b0;
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                beat = rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
                if (run_mode == run_corrupt && beat_count == corrupt_beat) begin
                    beat[corrupt_bit] = ~beat[corrupt_bit];
                    corrupt_applied = 1'b1;
                end
                avl_rdata <= beat;
                avl_rdata_valid <= 1'b1;
                beat_count++;
            end
            draw_bits(2, value);
            avl_ready <= (value != 0);  // ready about three cycles in four
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b0;
        ddr3_init_done <= 1'b0;
        ddr3_cal_success <= 1'b0;
        ddr3_cal_fail <= 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        assert ({avl_burstbegin, avl_write_req, avl_read_req, avl_addr, avl_wdata, avl_be,
                 avl_size} == '0)
        else fail_now("a request output was not low directly after reset");
        assert (leds_n == 3'b111)
        else fail_now($sformatf("error: leds_n = 0x%0h, expected 0x7", leds_n));
    endtask

    task automatic wait_leds_change(input int limit, input string what, output logic [2:0] value);
        logic [2:0] start;
        int waited;
        start = leds_n;
        waited = 0;
        while (leds_n == start && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (leds_n != start) else fail_now($sformatf("timeout waiting for the LEDs to %s", what));
        value = leds_n;
    endtask

    task automatic check_blinking();
        logic [2:0] value;
        logic [2:0] prev;
        wait_leds_change(3000, "start blinking", value);
        assert (value == 3'b000)
        else fail_now($sformatf("error: leds_n = 0x%0h, expected 0x0", value));
        repeat (6) begin
            prev = value;
            wait_leds_change(40, "toggle", value);
            assert (value == ~prev)
            else fail_now($sformatf("error: leds_n = 0x%0h, expected 0x%0h", value, ~prev));
        end
    endtask

    task automatic run_test(input int mode);
        logic [2:0] value;
        logic [2:0] count;
        run_mode = mode;
        draw_bits(4, corrupt_beat);
        draw_bits(6, corrupt_bit);
        apply_reset();
        @(posedge clk);
        ddr3_init_done <= 1'b1;
        ddr3_cal_success <= (mode != run_cal_fail);
        ddr3_cal_fail <= (mode == run_cal_fail);
        if (mode == run_clean) begin
            wait_leds_change(3000, "show a count", value);
            assert (write_count == num_words)
            else fail_now($sformatf("error: write_count = 0x%0h, expected 0x10", write_count));
            assert (beat_count == num_words)
            else fail_now($sformatf("error: beat_count = 0x%0h, expected 0x10", beat_count));
            count = 3'd1;
            repeat (10) begin
                assert (value == ~count)
                else fail_now($sformatf("error: leds_n = 0x%0h, expected 0x%0h", value, ~count));
                count = count + 3'd1;
                wait_leds_change(40, "advance the count", value);
            end
        end else begin
            check_blinking();
            if (mode == run_corrupt) begin
                assert (corrupt_applied) else fail_now("the corrupted read beat was never returned");
            end
        end
    endtask

    initial begin
        reset_n = 1'b0;
        avl_ready = 1'b0;
        avl_rdata_valid = 1'b0;
        avl_rdata = '0;
        ddr3_init_done = 1'b0;
        ddr3_cal_success = 1'b0;
        ddr3_cal_fail = 1'b0;
        run_mode = run_clean;
        run_test(run_clean);
        run_test(run_corrupt);
        run_test(run_cal_fail);
        if (checker_quiet) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_now("a protocol assertion failed in the bound checker");
        end
    end

endmodule

// ==== files.f ====
+incdir+include
logic/mem_test_pkg.sv
logic/cal_status_sync.sv
logic/mem_test_sequencer.sv
logic/mem_read_checker.sv
logic/status_led_driver.sv
logic/mem_test_top.sv
verif/mem_test_checker.sv
verif/mem_test_tb.sv
